/* tb.f */
soc_bus_pkg.sv
bus_xbar.sv
sram_slave.sv
clint_timer.sv
uart_tx_port.sv
soc_bus_top.sv
tb_clock.sv
soc_bus_assert.sv
soc_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_bus_pkg::*;

  localparam int          SRAM_AW      = 10;
  localparam int          PERIOD_NS    = 4;
  localparam int          RESET_CYCLES = 3;
  localparam int          NUM_ENTRIES  = 24;
  localparam int          WATCHDOG_NS  = (NUM_ENTRIES * 20 + RESET_CYCLES + 4) * PERIOD_NS;
  localparam logic [31:0] SEED         = 32'ha123_2615;

  localparam logic [1:0] CHK_NONE = 2'd0;
  localparam logic [1:0] CHK_EQ   = 2'd1;
  localparam logic [1:0] CHK_GT   = 2'd2;  // above the previous read

  typedef struct packed {
    logic       wr;
    addr_t      addr;
    data_t      wdata;
    strb_t      strb;
    data_t      rdata;
    logic [1:0] chk;
    resp_t      resp;
    logic       tx_chk;
    logic [7:0] tx_byte;
  } entry_t;

  logic       clk;
  logic       rstn;
  ar_chan_t   m_ar;
  logic       m_ar_valid;
  logic       m_ar_ready;
  r_chan_t    m_r;
  logic       m_r_valid;
  logic       m_r_ready;
  aw_chan_t   m_aw;
  logic       m_aw_valid;
  logic       m_aw_ready;
  w_chan_t    m_w;
  logic       m_w_valid;
  logic       m_w_ready;
  b_chan_t    m_b;
  logic       m_b_valid;
  logic       m_b_ready;
  logic [7:0] uart_tx_data;
  logic       uart_tx_valid;

  entry_t      tbl [NUM_ENTRIES];
  data_t       sram_model [int unsigned];
  logic [31:0] rng = SEED;
  data_t       prev_rdata = '0;
  int unsigned tx_count = 0;
  logic [7:0]  tx_last = '0;
  int unsigned data_errs = 0;
  int unsigned resp_errs = 0;
  int unsigned tx_errs = 0;
  int unsigned rst_errs = 0;

  tb_clock #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_tb_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  soc_bus_top #(
    .SRAM_AW (SRAM_AW)
  ) i_soc_bus_top (
    .clk           (clk),
    .rstn          (rstn),
    .m_ar          (m_ar),
    .m_ar_valid    (m_ar_valid),
    .m_ar_ready    (m_ar_ready),
    .m_r           (m_r),
    .m_r_valid     (m_r_valid),
    .m_r_ready     (m_r_ready),
    .m_aw          (m_aw),
    .m_aw_valid    (m_aw_valid),
    .m_aw_ready    (m_aw_ready),
    .m_w           (m_w),
    .m_w_valid     (m_w_valid),
    .m_w_ready     (m_w_ready),
    .m_b           (m_b),
    .m_b_valid     (m_b_valid),
    .m_b_ready     (m_b_ready),
    .uart_tx_data  (uart_tx_data),
    .uart_tx_valid (uart_tx_valid)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned next_stall();
    rng = lcg_step(rng);
    return int'(rng[31:30]);  // 0 to 3 cycles
  endfunction

  function automatic entry_t write_entry(input addr_t a, input data_t d, input strb_t s,
                                         input resp_t rsp, input logic tx, input logic [7:0] tb);
    return '{wr: 1'b1, addr: a, wdata: d, strb: s, rdata: '0, chk: CHK_NONE,
             resp: rsp, tx_chk: tx, tx_byte: tb};
  endfunction

  function automatic entry_t read_entry(input addr_t a, input data_t d, input logic [1:0] c,
                                        input resp_t rsp);
    return '{wr: 1'b0, addr: a, wdata: '0, strb: '0, rdata: d, chk: c,
             resp: rsp, tx_chk: 1'b0, tx_byte: '0};
  endfunction

  function automatic logic in_sram(input addr_t a);
    return a[31:27] == SRAM_BASE_HI;
  endfunction

  function automatic int unsigned word_index(input addr_t a);
    return (a >> 2) % (32'd1 << SRAM_AW);  // wraps modulo the sram size
  endfunction

  function automatic data_t model_read(input addr_t a);
    return sram_model.exists(word_index(a)) ? sram_model[word_index(a)] : '0;
  endfunction

  function automatic void model_write(input addr_t a, input data_t d, input strb_t s);
    data_t word;
    word = model_read(a);
    for (int i = 0; i < 4; i++) begin
      if (s[i]) word[8*i +: 8] = d[8*i +: 8];
    end
    sram_model[word_index(a)] = word;
  endfunction

  task automatic fill_table();
    addr_t alias_a;
    alias_a = 32'h8000_0010 + (32'd4 << SRAM_AW);  // same word as 0x8000_0010
    tbl[0]  = write_entry(32'h8000_0000, 32'h1122_3344, 4'hf, RESP_OKAY, 1'b0, 8'h00);
    tbl[1]  = write_entry(32'h8000_0004, 32'hdead_beef, 4'hf, RESP_OKAY, 1'b0, 8'h00);
    tbl[2]  = write_entry(32'h8000_0004, 32'h5566_7788, 4'h5, RESP_OKAY, 1'b0, 8'h00);
    tbl[3]  = read_entry(32'h8000_0000, '0, CHK_EQ, RESP_OKAY);
    tbl[4]  = read_entry(32'h8000_0004, '0, CHK_EQ, RESP_OKAY);
    tbl[5]  = write_entry(32'h8000_0010, 32'hcafe_f00d, 4'hf, RESP_OKAY, 1'b0, 8'h00);
    tbl[6]  = write_entry(alias_a, 32'h0000_00a5, 4'h1, RESP_OKAY, 1'b0, 8'h00);
    tbl[7]  = read_entry(32'h8000_0010, '0, CHK_EQ, RESP_OKAY);
    tbl[8]  = read_entry(alias_a, '0, CHK_EQ, RESP_OKAY);
    tbl[9]  = read_entry(CLINT_MTIME_ADDR + 32'd4, '0, CHK_EQ, RESP_OKAY);
    tbl[10] = read_entry(CLINT_MTIME_ADDR, '0, CHK_NONE, RESP_OKAY);
    tbl[11] = read_entry(CLINT_MTIME_ADDR, '0, CHK_GT, RESP_OKAY);
    tbl[12] = write_entry(UART_TX_ADDR, 32'h0000_0041, 4'h1, RESP_OKAY, 1'b1, 8'h41);
    tbl[13] = write_entry(UART_TX_ADDR, 32'h1234_5678, 4'he, RESP_OKAY, 1'b0, 8'h00);
    tbl[14] = write_entry(UART_TX_ADDR, 32'h0000_005a, 4'hf, RESP_OKAY, 1'b1, 8'h5a);
    // decode errors
    tbl[15] = read_entry(32'h4000_0000, '0, CHK_EQ, RESP_DECERR);
    tbl[16] = read_entry(UART_TX_ADDR, '0, CHK_EQ, RESP_DECERR);
    tbl[17] = write_entry(CLINT_MTIME_ADDR, 32'h0000_0001, 4'hf, RESP_DECERR, 1'b0, 8'h00);
    tbl[18] = write_entry(32'h0000_1000, 32'h0000_0002, 4'hf, RESP_DECERR, 1'b0, 8'h00);
    tbl[19] = read_entry(32'h8000_0004, '0, CHK_EQ, RESP_OKAY);
    tbl[20] = write_entry(32'h8000_0ffc, 32'h0bad_cafe, 4'hf, RESP_OKAY, 1'b0, 8'h00);
    tbl[21] = read_entry(32'h8000_0ffc, '0, CHK_EQ, RESP_OKAY);
    tbl[22] = write_entry(32'h8000_0ffc, 32'hffff_ffff, 4'h6, RESP_OKAY, 1'b0, 8'h00);
    tbl[23] = read_entry(32'h8000_0ffc, '0, CHK_EQ, RESP_OKAY);
  endtask

  task automatic check_idle(input string name, input logic val);
    assert (val === 1'b0) else begin
      $display("[ERROR] %s after reset: got %h expected %h", name, val, 1'b0);
      rst_errs++;
    end
  endtask

  // ----------------------------------------------------------------------
  // master driver
  // ----------------------------------------------------------------------
  task automatic apply_read(input entry_t e);
    int unsigned stall;
    data_t       exp_data;
    r_chan_t     rsp;
    @(posedge clk);
    m_ar.addr  <= e.addr;
    m_ar_valid <= 1'b1;
    @(posedge clk);
    while (!m_ar_ready) @(posedge clk);
    m_ar_valid <= 1'b0;
    stall = next_stall();
    repeat (stall) @(posedge clk);
    m_r_ready <= 1'b1;
    @(posedge clk);
    while (!m_r_valid) @(posedge clk);
    rsp = m_r;
    m_r_ready <= 1'b0;
    @(negedge clk);
    assert (rsp.resp == e.resp) else begin
      $display("[ERROR] m_r.resp at %h: got %h expected %h", e.addr, rsp.resp, e.resp);
      resp_errs++;
    end
    if (e.chk == CHK_EQ) begin
      exp_data = e.rdata;
      if (in_sram(e.addr) && e.resp == RESP_OKAY) exp_data = model_read(e.addr);
      assert (rsp.data === exp_data) else begin
        $display("[ERROR] m_r.data at %h: got %h expected %h", e.addr, rsp.data, exp_data);
        data_errs++;
      end
    end else if (e.chk == CHK_GT) begin
      assert (rsp.data > prev_rdata) else begin
        $display("[ERROR] m_r.data at %h: got %h expected above %h",
                 e.addr, rsp.data, prev_rdata);
        data_errs++;
      end
    end
    prev_rdata = rsp.data;
  endtask

  task automatic apply_write(input entry_t e);
    int unsigned stall;
    int unsigned tx_before;
    int unsigned tx_exp;
    b_chan_t     rsp;
    tx_before = tx_count;
    tx_exp    = e.tx_chk ? 1 : 0;
    @(posedge clk);
    m_aw.addr  <= e.addr;
    m_w.data   <= e.wdata;
    m_w.strb   <= e.strb;
    m_aw_valid <= 1'b1;
    m_w_valid  <= 1'b1;  // aw and w always together
    @(posedge clk);
    while (!(m_aw_ready && m_w_ready)) @(posedge clk);
    m_aw_valid <= 1'b0;
    m_w_valid  <= 1'b0;
    stall = next_stall();
    repeat (stall) @(posedge clk);
    m_b_ready <= 1'b1;
    @(posedge clk);
    while (!m_b_valid) @(posedge clk);
    rsp = m_b;
    m_b_ready <= 1'b0;
    @(negedge clk);
    assert (rsp.resp == e.resp) else begin
      $display("[ERROR] m_b.resp at %h: got %h expected %h", e.addr, rsp.resp, e.resp);
      resp_errs++;
    end
    assert (tx_count - tx_before == tx_exp) else begin
      $display("[ERROR] uart_tx_valid pulses at %h: got %h expected %h",
               e.addr, tx_count - tx_before, tx_exp);
      tx_errs++;
    end
    if (e.tx_chk) begin
      assert (tx_last == e.tx_byte) else begin
        $display("[ERROR] uart_tx_data: got %h expected %h", tx_last, e.tx_byte);
        tx_errs++;
      end
    end
    if (in_sram(e.addr) && e.resp == RESP_OKAY) model_write(e.addr, e.wdata, e.strb);
  endtask

  // uart pulse monitor
  always @(posedge clk) begin
    if (!rstn && uart_tx_valid) begin
      tx_count <= tx_count + 1;
      tx_last  <= uart_tx_data;
    end
  end

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    m_ar       = '0;
    m_ar_valid = 1'b0;
    m_r_ready  = 1'b0;
    m_aw       = '0;
    m_aw_valid = 1'b0;
    m_w        = '0;
    m_w_valid  = 1'b0;
    m_b_ready  = 1'b0;
    fill_table();
    @(posedge clk);
    while (rstn) @(posedge clk);
    @(negedge clk);
    check_idle("m_r_valid", m_r_valid);
    check_idle("m_b_valid", m_b_valid);
    check_idle("uart_tx_valid", uart_tx_valid);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].wr) apply_write(tbl[i]);
      else apply_read(tbl[i]);
    end
    $display("error counts: data %0d, resp %0d, uart %0d, reset %0d",
             data_errs, resp_errs, tx_errs, rst_errs);
    if (data_errs + resp_errs + tx_errs + rst_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the bus did not finish the test table in time");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* soc_bus_assert.sv */
`default_nettype none

module soc_bus_assert (
  input logic                  clk,
  input logic                  rstn,
  input soc_bus_pkg::ar_chan_t m_ar,
  input logic                  m_ar_valid,
  input logic                  m_ar_ready,
  input soc_bus_pkg::r_chan_t  m_r,
  input logic                  m_r_valid,
  input logic                  m_r_ready,
  input soc_bus_pkg::aw_chan_t m_aw,
  input logic                  m_aw_valid,
  input logic                  m_aw_ready,
  input soc_bus_pkg::w_chan_t  m_w,
  input logic                  m_w_valid,
  input logic                  m_w_ready,
  input soc_bus_pkg::b_chan_t  m_b,
  input logic                  m_b_valid,
  input logic                  m_b_ready,
  input logic                  uart_tx_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------------------------------------
  // master-side handshake rules
  // ----------------------------------------------------------------------
  ar_hold: assert property (@(posedge clk) disable iff (rstn)
    m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
    else $error("ar valid dropped or address changed before ready");

  aw_hold: assert property (@(posedge clk) disable iff (rstn)
    m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
    else $error("aw valid dropped or address changed before ready");

  w_hold: assert property (@(posedge clk) disable iff (rstn)
    m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
    else $error("w valid dropped or data changed before ready");

  // responses held under back-pressure
  r_hold: assert property (@(posedge clk) disable iff (rstn)
    m_r_valid && !m_r_ready |=> m_r_valid && $stable(m_r))
    else $error("read response dropped or changed before ready");

  b_hold: assert property (@(posedge clk) disable iff (rstn)
    m_b_valid && !m_b_ready |=> m_b_valid && $stable(m_b))
    else $error("write response dropped or changed before ready");

  aw_w_ready_eq: assert property (@(posedge clk) m_aw_ready == m_w_ready)
    else $error("aw ready and w ready differ");

  r_after_ar: assert property (@(posedge clk) disable iff (rstn)
    m_ar_valid && m_ar_ready |=> m_r_valid)
    else $error("read data valid did not follow the address handshake by one cycle");

  // second reset cycle onward, flops have been cleared
  idle_in_reset: assert property (@(posedge clk)
    rstn && $past(rstn) |-> !m_r_valid && !m_b_valid && !uart_tx_valid)
    else $error("a valid is high during reset");

endmodule

bind soc_bus_top soc_bus_assert i_soc_bus_assert (
  .clk           (clk),
  .rstn          (rstn),
  .m_ar          (m_ar),
  .m_ar_valid    (m_ar_valid),
  .m_ar_ready    (m_ar_ready),
  .m_r           (m_r),
  .m_r_valid     (m_r_valid),
  .m_r_ready     (m_r_ready),
  .m_aw          (m_aw),
  .m_aw_valid    (m_aw_valid),
  .m_aw_ready    (m_aw_ready),
  .m_w           (m_w),
  .m_w_valid     (m_w_valid),
  .m_w_ready     (m_w_ready),
  .m_b           (m_b),
  .m_b_valid     (m_b_valid),
  .m_b_ready     (m_b_ready),
  .uart_tx_valid (uart_tx_valid)
);

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset is active high
  initial begin
    rstn = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b0;
  end

endmodule

`default_nettype wire

/* soc_bus_top.sv */
`default_nettype none

module soc_bus_top #(
  parameter int unsigned SRAM_AW = 10
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  soc_bus_pkg::ar_chan_t m_ar,
  input  logic                  m_ar_valid,
  output logic                  m_ar_ready,
  output soc_bus_pkg::r_chan_t  m_r,
  output logic                  m_r_valid,
  input  logic                  m_r_ready,
  input  soc_bus_pkg::aw_chan_t m_aw,
  input  logic                  m_aw_valid,
  output logic                  m_aw_ready,
  input  soc_bus_pkg::w_chan_t  m_w,
  input  logic                  m_w_valid,
  output logic                  m_w_ready,
  output soc_bus_pkg::b_chan_t  m_b,
  output logic                  m_b_valid,
  input  logic                  m_b_ready,
  output logic [7:0]            uart_tx_data,
  output logic                  uart_tx_valid
);
  import soc_bus_pkg::*;

  // ----------------------------------------------------------------------
  // crossbar to slave channels
  // ----------------------------------------------------------------------
  ar_chan_t sram_ar, clint_ar;
  r_chan_t  sram_r, clint_r;
  aw_chan_t sram_aw, uart_aw;
  w_chan_t  sram_w, uart_w;
  b_chan_t  sram_b, uart_b;
  logic     sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic     clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
  logic     sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
  logic     sram_b_valid, sram_b_ready;
  logic     uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
  logic     uart_b_valid, uart_b_ready;

  bus_xbar i_bus_xbar (
    .clk            (clk),
    .rstn           (rstn),
    .m_ar           (m_ar),
    .m_ar_valid     (m_ar_valid),
    .m_ar_ready     (m_ar_ready),
    .m_r            (m_r),
    .m_r_valid      (m_r_valid),
    .m_r_ready      (m_r_ready),
    .m_aw           (m_aw),
    .m_aw_valid     (m_aw_valid),
    .m_aw_ready     (m_aw_ready),
    .m_w            (m_w),
    .m_w_valid      (m_w_valid),
    .m_w_ready      (m_w_ready),
    .m_b            (m_b),
    .m_b_valid      (m_b_valid),
    .m_b_ready      (m_b_ready),
    .sram_ar        (sram_ar),
    .sram_ar_valid  (sram_ar_valid),
    .sram_ar_ready  (sram_ar_ready),
    .sram_r         (sram_r),
    .sram_r_valid   (sram_r_valid),
    .sram_r_ready   (sram_r_ready),
    .clint_ar       (clint_ar),
    .clint_ar_valid (clint_ar_valid),
    .clint_ar_ready (clint_ar_ready),
    .clint_r        (clint_r),
    .clint_r_valid  (clint_r_valid),
    .clint_r_ready  (clint_r_ready),
    .sram_aw        (sram_aw),
    .sram_w         (sram_w),
    .sram_aw_valid  (sram_aw_valid),
    .sram_w_valid   (sram_w_valid),
    .sram_aw_ready  (sram_aw_ready),
    .sram_w_ready   (sram_w_ready),
    .sram_b         (sram_b),
    .sram_b_valid   (sram_b_valid),
    .sram_b_ready   (sram_b_ready),
    .uart_aw        (uart_aw),
    .uart_w         (uart_w),
    .uart_aw_valid  (uart_aw_valid),
    .uart_w_valid   (uart_w_valid),
    .uart_aw_ready  (uart_aw_ready),
    .uart_w_ready   (uart_w_ready),
    .uart_b         (uart_b),
    .uart_b_valid   (uart_b_valid),
    .uart_b_ready   (uart_b_ready)
  );

  sram_slave #(
    .SRAM_AW (SRAM_AW)
  ) i_sram_slave (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (sram_ar),
    .ar_valid (sram_ar_valid),
    .ar_ready (sram_ar_ready),
    .r        (sram_r),
    .r_valid  (sram_r_valid),
    .r_ready  (sram_r_ready),
    .aw       (sram_aw),
    .aw_valid (sram_aw_valid),
    .aw_ready (sram_aw_ready),
    .w        (sram_w),
    .w_valid  (sram_w_valid),
    .w_ready  (sram_w_ready),
    .b        (sram_b),
    .b_valid  (sram_b_valid),
    .b_ready  (sram_b_ready)
  );

  clint_timer i_clint_timer (
    .clk      (clk),
    .rstn     (rstn),
    .ar       (clint_ar),
    .ar_valid (clint_ar_valid),
    .ar_ready (clint_ar_ready),
    .r        (clint_r),
    .r_valid  (clint_r_valid),
    .r_ready  (clint_r_ready)
  );

  uart_tx_port i_uart_tx_port (
    .clk      (clk),
    .rstn     (rstn),
    .aw       (uart_aw),
    .aw_valid (uart_aw_valid),
    .aw_ready (uart_aw_ready),
    .w        (uart_w),
    .w_valid  (uart_w_valid),
    .w_ready  (uart_w_ready),
    .b        (uart_b),
    .b_valid  (uart_b_valid),
    .b_ready  (uart_b_ready),
    .tx_data  (uart_tx_data),
    .tx_valid (uart_tx_valid)
  );

endmodule

`default_nettype wire

/* uart_tx_port.sv */
`default_nettype none

module uart_tx_port (
  input  logic                  clk,
  input  logic                  rstn,
  input  soc_bus_pkg::aw_chan_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  soc_bus_pkg::w_chan_t  w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output soc_bus_pkg::b_chan_t  b,
  output logic                  b_valid,
  input  logic                  b_ready,
  output logic [7:0]            tx_data,
  output logic                  tx_valid
);
  import soc_bus_pkg::*;

  logic wr_fire;

  assign wr_fire  = aw_valid && w_valid && !b_valid;
  assign aw_ready = wr_fire;
  assign w_ready  = wr_fire;
  assign b.resp   = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      b_valid  <= 1'b0;
      tx_valid <= 1'b0;
    end else begin
      tx_valid <= wr_fire && w.strb[0];  // single-cycle pulse
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // low byte of the write data
  always_ff @(posedge clk) begin
    if (wr_fire) tx_data <= w.data[7:0];
  end

endmodule

`default_nettype wire

/* clint_timer.sv */
`default_nettype none

module clint_timer (
  input  logic                  clk,
  input  logic                  rstn,
  input  soc_bus_pkg::ar_chan_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output soc_bus_pkg::r_chan_t  r,
  output logic                  r_valid,
  input  logic                  r_ready
);
  import soc_bus_pkg::*;

  logic [63:0] mtime;
  data_t       rdata_q;
  logic        ar_fire;

  // ----------------------------------------------------------------------
  // free-running counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------
  assign ar_ready = !r_valid;
  assign ar_fire  = ar_valid && ar_ready;
  assign r.data   = rdata_q;
  assign r.resp   = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
    end else if (ar_fire) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // value before this edge's increment
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= ar.addr[2] ? mtime[63:32] : mtime[31:0];  // bit 2 picks high word
    end
  end

endmodule

`default_nettype wire

/* sram_slave.sv */
`default_nettype none

module sram_slave #(
  parameter int unsigned SRAM_AW = 10  // word address bits
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  soc_bus_pkg::ar_chan_t ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output soc_bus_pkg::r_chan_t  r,
  output logic                  r_valid,
  input  logic                  r_ready,
  input  soc_bus_pkg::aw_chan_t aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  soc_bus_pkg::w_chan_t  w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output soc_bus_pkg::b_chan_t  b,
  output logic                  b_valid,
  input  logic                  b_ready
);
  import soc_bus_pkg::*;

  localparam int unsigned DEPTH = 1 << SRAM_AW;

  data_t              mem [0:DEPTH-1];
  data_t              rdata_q;
  logic [SRAM_AW-1:0] rd_idx;
  logic [SRAM_AW-1:0] wr_idx;
  logic               ar_fire;
  logic               wr_fire;

  // upper address bits dropped, so the array wraps
  assign rd_idx = ar.addr[SRAM_AW+1:2];
  assign wr_idx = aw.addr[SRAM_AW+1:2];

  // ----------------------------------------------------------------------
  // read
  // ----------------------------------------------------------------------
  assign ar_ready = !r_valid;
  assign ar_fire  = ar_valid && ar_ready;
  assign r.data   = rdata_q;
  assign r.resp   = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      r_valid <= 1'b0;
    end else if (ar_fire) begin
      r_valid <= 1'b1;
    end else if (r_ready) begin
      r_valid <= 1'b0;  // hold until taken
    end
  end

  // ----------------------------------------------------------------------
  // write
  // ----------------------------------------------------------------------
  assign wr_fire  = aw_valid && w_valid && !b_valid;
  assign aw_ready = wr_fire;
  assign w_ready  = wr_fire;
  assign b.resp   = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      b_valid <= 1'b0;
    end else if (wr_fire) begin
      b_valid <= 1'b1;
    end else if (b_ready) begin
      b_valid <= 1'b0;
    end
  end

  // array and read data
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem[rd_idx];
    end
    if (wr_fire) begin
      for (int i = 0; i < 4; i++) begin
        if (w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];  // lane merge
      end
    end
  end

endmodule

`default_nettype wire

/* bus_xbar.sv */
`default_nettype none

module bus_xbar (
  input  logic                  clk,
  input  logic                  rstn,
  // master side
  input  soc_bus_pkg::ar_chan_t m_ar,
  input  logic                  m_ar_valid,
  output logic                  m_ar_ready,
  output soc_bus_pkg::r_chan_t  m_r,
  output logic                  m_r_valid,
  input  logic                  m_r_ready,
  input  soc_bus_pkg::aw_chan_t m_aw,
  input  logic                  m_aw_valid,
  output logic                  m_aw_ready,
  input  soc_bus_pkg::w_chan_t  m_w,
  input  logic                  m_w_valid,
  output logic                  m_w_ready,
  output soc_bus_pkg::b_chan_t  m_b,
  output logic                  m_b_valid,
  input  logic                  m_b_ready,
  // sram read
  output soc_bus_pkg::ar_chan_t sram_ar,
  output logic                  sram_ar_valid,
  input  logic                  sram_ar_ready,
  input  soc_bus_pkg::r_chan_t  sram_r,
  input  logic                  sram_r_valid,
  output logic                  sram_r_ready,
  // timer
  output soc_bus_pkg::ar_chan_t clint_ar,
  output logic                  clint_ar_valid,
  input  logic                  clint_ar_ready,
  input  soc_bus_pkg::r_chan_t  clint_r,
  input  logic                  clint_r_valid,
  output logic                  clint_r_ready,
  // sram write
  output soc_bus_pkg::aw_chan_t sram_aw,
  output soc_bus_pkg::w_chan_t  sram_w,
  output logic                  sram_aw_valid,
  output logic                  sram_w_valid,
  input  logic                  sram_aw_ready,
  input  logic                  sram_w_ready,
  input  soc_bus_pkg::b_chan_t  sram_b,
  input  logic                  sram_b_valid,
  output logic                  sram_b_ready,
  // uart
  output soc_bus_pkg::aw_chan_t uart_aw,
  output soc_bus_pkg::w_chan_t  uart_w,
  output logic                  uart_aw_valid,
  output logic                  uart_w_valid,
  input  logic                  uart_aw_ready,
  input  logic                  uart_w_ready,
  input  soc_bus_pkg::b_chan_t  uart_b,
  input  logic                  uart_b_valid,
  output logic                  uart_b_ready
);
  import soc_bus_pkg::*;

  // target codes, DEV is clint for reads and uart for writes
  localparam logic [1:0] TGT_SRAM = 2'd0;
  localparam logic [1:0] TGT_DEV  = 2'd1;
  localparam logic [1:0] TGT_ERR  = 2'd2;

  // ----------------------------------------------------------------------
  // read
  // ----------------------------------------------------------------------
  logic [1:0] ar_tgt;
  logic       ar_sel_ready;
  logic       ar_fire;
  logic       r_fire;
  logic       rd_busy;  // one read outstanding
  logic [1:0] rd_own;

  always_comb begin
    ar_tgt       = TGT_ERR;
    ar_sel_ready = 1'b1;  // miss accepted at once
    if (m_ar.addr[31:27] == SRAM_BASE_HI) begin
      ar_tgt       = TGT_SRAM;
      ar_sel_ready = sram_ar_ready;
    end else if (m_ar.addr[31:3] == CLINT_MTIME_ADDR[31:3]) begin
      ar_tgt       = TGT_DEV;
      ar_sel_ready = clint_ar_ready;
    end
  end

  assign sram_ar        = m_ar;
  assign clint_ar       = m_ar;
  assign sram_ar_valid  = m_ar_valid && !rd_busy && (ar_tgt == TGT_SRAM);
  assign clint_ar_valid = m_ar_valid && !rd_busy && (ar_tgt == TGT_DEV);
  assign m_ar_ready     = !rd_busy && ar_sel_ready;
  assign ar_fire        = m_ar_valid && m_ar_ready;

  // steer r from the owner only
  always_comb begin
    m_r           = '0;
    m_r_valid     = 1'b0;
    sram_r_ready  = 1'b0;
    clint_r_ready = 1'b0;
    if (rd_busy) begin
      case (rd_own)
        TGT_SRAM: begin
          m_r          = sram_r;
          m_r_valid    = sram_r_valid;
          sram_r_ready = m_r_ready;
        end
        TGT_DEV: begin
          m_r           = clint_r;
          m_r_valid     = clint_r_valid;
          clint_r_ready = m_r_ready;
        end
        default: begin
          m_r.resp  = RESP_DECERR;  // data stays 0
          m_r_valid = 1'b1;
        end
      endcase
    end
  end

  assign r_fire = m_r_valid && m_r_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_busy <= 1'b0;
      rd_own  <= TGT_ERR;
    end else if (ar_fire) begin
      rd_busy <= 1'b1;
      rd_own  <= ar_tgt;
    end else if (r_fire) begin
      rd_busy <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // write, aw and w taken together
  // ----------------------------------------------------------------------
  logic       wr_req;
  logic [1:0] aw_tgt;
  logic       aw_sel_ready;
  logic       wr_ready;
  logic       wr_fire;
  logic       b_fire;
  logic       wr_busy;
  logic [1:0] wr_own;

  assign wr_req = m_aw_valid && m_w_valid;

  always_comb begin
    aw_tgt       = TGT_ERR;
    aw_sel_ready = 1'b1;
    if (m_aw.addr[31:27] == SRAM_BASE_HI) begin
      aw_tgt       = TGT_SRAM;
      aw_sel_ready = sram_aw_ready && sram_w_ready;
    end else if (m_aw.addr[31:3] == UART_TX_ADDR[31:3]) begin
      aw_tgt       = TGT_DEV;
      aw_sel_ready = uart_aw_ready && uart_w_ready;
    end
  end

  assign sram_aw       = m_aw;
  assign sram_w        = m_w;
  assign uart_aw       = m_aw;
  assign uart_w        = m_w;
  assign sram_aw_valid = wr_req && !wr_busy && (aw_tgt == TGT_SRAM);
  assign sram_w_valid  = sram_aw_valid;
  assign uart_aw_valid = wr_req && !wr_busy && (aw_tgt == TGT_DEV);
  assign uart_w_valid  = uart_aw_valid;

  assign wr_ready   = wr_req && !wr_busy && aw_sel_ready;
  assign m_aw_ready = wr_ready;
  assign m_w_ready  = wr_ready;  // always equal to aw_ready
  assign wr_fire    = wr_ready;

  always_comb begin
    m_b          = '0;
    m_b_valid    = 1'b0;
    sram_b_ready = 1'b0;
    uart_b_ready = 1'b0;
    if (wr_busy) begin
      case (wr_own)
        TGT_SRAM: begin
          m_b          = sram_b;
          m_b_valid    = sram_b_valid;
          sram_b_ready = m_b_ready;
        end
        TGT_DEV: begin
          m_b          = uart_b;
          m_b_valid    = uart_b_valid;
          uart_b_ready = m_b_ready;
        end
        default: begin
          m_b.resp  = RESP_DECERR;
          m_b_valid = 1'b1;
        end
      endcase
    end
  end

  assign b_fire = m_b_valid && m_b_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_busy <= 1'b0;
      wr_own  <= TGT_ERR;
    end else if (wr_fire) begin
      wr_busy <= 1'b1;
      wr_own  <= aw_tgt;
    end else if (b_fire) begin
      wr_busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // ----------------------------------------------------------------------
  // base types
  // ----------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // one bit per byte lane
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;  // no slave at this address

  // ----------------------------------------------------------------------
  // channel payloads, valid and ready travel beside them
  // ----------------------------------------------------------------------
  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_chan_t;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_t resp;
  } b_chan_t;

  // ----------------------------------------------------------------------
  // address map
  // ----------------------------------------------------------------------
  // sram owns addr[31:27] == 5'h10, i.e. 0x8000_0000 upward
  localparam logic [4:0] SRAM_BASE_HI = 5'h10;

  // mtime low word, high word at +4, window is addr[31:3]
  localparam addr_t CLINT_MTIME_ADDR = 32'ha000_0048;

  // uart tx register, 8-byte window as well
  localparam addr_t UART_TX_ADDR = 32'ha000_03f8;

endpackage

`default_nettype wire
